// ==== include/snoop_cfg.svh ====
/*
 * Build-time constants for the control-flow trace snooper.
 * Included by the package and by every module that sizes a port
 * or decodes a register offset.
 */

`ifndef SNOOP_CFG_SVH
`define SNOOP_CFG_SVH

// ------------------------------
// Widths and depth
// ------------------------------
`define SNOOP_PC_W       32
`define SNOOP_WB_AW      5
`define SNOOP_BUF_DEPTH  16
`define SNOOP_LEVEL_W    5

// ------------------------------
// Register byte offsets
// ------------------------------
`define SNOOP_REG_CTRL   5'h00
`define SNOOP_REG_WMARK  5'h04
`define SNOOP_REG_TRIG   5'h08
`define SNOOP_REG_STATUS 5'h0C
`define SNOOP_REG_SRC    5'h10
`define SNOOP_REG_DST    5'h14
`define SNOOP_REG_INFO   5'h18

`endif

// ==== source/snoop_pkg.sv ====
/*
 * Shared types of the trace snooper: the branch kind and privilege
 * encodings presented by each hart, and the packed record that moves
 * from the selection stage into the buffer and trigger logic.
 */

`include "snoop_cfg.svh"

package snoop_pkg;

  // Control-flow kind as retired by the core
  typedef enum logic [2:0] {
    BR_COND = 3'd0,
    BR_JUMP = 3'd1,
    BR_CALL = 3'd2,
    BR_RET  = 3'd3,
    BR_TRAP = 3'd4
  } br_kind_e;

  // RISC-V privilege level, encoding 2 is reserved
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_e;

  // ------------------------------
  // One captured event, 69 bits
  // ------------------------------
  typedef struct packed {
    logic [`SNOOP_PC_W-1:0] src_pc;
    logic [`SNOOP_PC_W-1:0] dst_pc;
    br_kind_e               kind;
    priv_e                  priv;
  } trace_rec_t;

endpackage

// ==== source/trace_select.sv ====
/*
 * Front end of the snooper. Picks the event stream of one hart,
 * drops events that are disabled or masked by kind, and registers
 * the survivors as trace records with one cycle of latency.
 */

`timescale 1ns/1ns
`include "snoop_cfg.svh"

module trace_select (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   hart0_valid_i,
  input  logic [`SNOOP_PC_W-1:0] hart0_src_pc_i,
  input  logic [`SNOOP_PC_W-1:0] hart0_dst_pc_i,
  input  snoop_pkg::br_kind_e    hart0_kind_i,
  input  snoop_pkg::priv_e       hart0_priv_i,
  input  logic                   hart1_valid_i,
  input  logic [`SNOOP_PC_W-1:0] hart1_src_pc_i,
  input  logic [`SNOOP_PC_W-1:0] hart1_dst_pc_i,
  input  snoop_pkg::br_kind_e    hart1_kind_i,
  input  snoop_pkg::priv_e       hart1_priv_i,
  input  logic                   cfg_enable_i,
  input  logic                   cfg_core_sel_i,
  input  logic [4:0]             cfg_kind_mask_i,
  output snoop_pkg::trace_rec_t  rec_o,
  output logic                   rec_valid_o
);
  import snoop_pkg::*;

  logic                   sel_valid;
  logic [`SNOOP_PC_W-1:0] sel_src;
  logic [`SNOOP_PC_W-1:0] sel_dst;
  br_kind_e               sel_kind;
  priv_e                  sel_priv;
  logic [7:0]             mask_ext;
  logic                   accept;
  trace_rec_t             rec_q;
  logic                   rec_valid_q;

  // Hart multiplexer
  always_comb begin
    if (cfg_core_sel_i) begin
      sel_valid = hart1_valid_i;
      sel_src   = hart1_src_pc_i;
      sel_dst   = hart1_dst_pc_i;
      sel_kind  = hart1_kind_i;
      sel_priv  = hart1_priv_i;
    end else begin
      sel_valid = hart0_valid_i;
      sel_src   = hart0_src_pc_i;
      sel_dst   = hart0_dst_pc_i;
      sel_kind  = hart0_kind_i;
      sel_priv  = hart0_priv_i;
    end
  end

  // Undefined kinds 5..7 see a zero mask bit and are never captured
  assign mask_ext = {3'b000, cfg_kind_mask_i};
  assign accept   = cfg_enable_i && sel_valid && mask_ext[sel_kind];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rec_valid_q <= 1'b0;
    end else begin
      rec_valid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_q <= '{src_pc: sel_src, dst_pc: sel_dst, kind: sel_kind, priv: sel_priv};
    end
  end

  assign rec_o       = rec_q;
  assign rec_valid_o = rec_valid_q;

endmodule

// ==== source/trace_buffer.sv ====
/*
 * Circular FIFO holding accepted trace records until software drains
 * them. Reports the head entry, the fill level and a sticky overflow
 * flag. Records that arrive while full are lost.
 */

`timescale 1ns/1ns
`include "snoop_cfg.svh"

module trace_buffer #(
  parameter int DEPTH = `SNOOP_BUF_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  snoop_pkg::trace_rec_t    rec_i,
  input  logic                     rec_valid_i,
  input  logic                     pop_i,
  input  logic                     ovf_clr_i,
  output snoop_pkg::trace_rec_t    head_o,
  output logic                     empty_o,
  output logic [`SNOOP_LEVEL_W-1:0] level_o,
  output logic                     overflow_o
);
  import snoop_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [`SNOOP_LEVEL_W-1:0] FULL_LEVEL = `SNOOP_LEVEL_W'(DEPTH);

  trace_rec_t                mem_q [DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [`SNOOP_LEVEL_W-1:0] level_q;
  logic                      overflow_q;
  logic                      full;
  logic                      empty;
  logic                      do_push;
  logic                      do_pop;

  assign full    = (level_q == FULL_LEVEL);
  assign empty   = (level_q == '0);
  assign do_push = rec_valid_i && !full;
  assign do_pop  = pop_i && !empty;

  // ------------------------------
  // Pointers, level and overflow
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
      // A drop in the same cycle as a clear keeps the flag set
      if (rec_valid_i && full) begin
        overflow_q <= 1'b1;
      end else if (ovf_clr_i) begin
        overflow_q <= 1'b0;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  assign head_o     = mem_q[rd_ptr_q];
  assign empty_o    = empty;
  assign level_o    = level_q;
  assign overflow_o = overflow_q;

endmodule

// ==== source/trigger_unit.sv ====
/*
 * Watches the accepted record stream for a programmed target address.
 * A match while enabled sets a sticky hit that software clears
 * through the status register.
 */

`timescale 1ns/1ns
`include "snoop_cfg.svh"

module trigger_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  snoop_pkg::trace_rec_t  rec_i,
  input  logic                   rec_valid_i,
  input  logic                   cfg_trig_en_i,
  input  logic [`SNOOP_PC_W-1:0] cfg_trig_addr_i,
  input  logic                   hit_clr_i,
  output logic                   hit_o
);

  logic match;
  logic hit_q;

  // Only records that passed the selection filter reach here
  assign match = rec_valid_i && cfg_trig_en_i && (rec_i.dst_pc == cfg_trig_addr_i);

  // ------------------------------
  // Sticky hit
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hit_q <= 1'b0;
    end else if (match) begin
      // New hit wins over a clear in the same cycle
      hit_q <= 1'b1;
    end else if (hit_clr_i) begin
      hit_q <= 1'b0;
    end
  end

  assign hit_o = hit_q;

endmodule

// ==== source/snoop_regs.sv ====
/*
 * Wishbone classic register port of the snooper. Holds the control,
 * watermark and trigger registers, presents buffer and trigger state,
 * pops the buffer on INFO reads and drives the two interrupts.
 */

`timescale 1ns/1ns
`include "snoop_cfg.svh"

module snoop_regs (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`SNOOP_WB_AW-1:0]   wb_adr_i,
  input  logic [31:0]               wb_dat_i,
  input  snoop_pkg::trace_rec_t     head_i,
  input  logic                      empty_i,
  input  logic [`SNOOP_LEVEL_W-1:0] level_i,
  input  logic                      overflow_i,
  input  logic                      hit_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      cfg_enable_o,
  output logic                      cfg_core_sel_o,
  output logic [4:0]                cfg_kind_mask_o,
  output logic                      cfg_trig_en_o,
  output logic [`SNOOP_PC_W-1:0]    cfg_trig_addr_o,
  output logic                      pop_o,
  output logic                      ovf_clr_o,
  output logic                      hit_clr_o,
  output logic                      watermark_irq_o,
  output logic                      trigger_irq_o
);

  typedef enum logic [`SNOOP_WB_AW-1:0] {
    REG_CTRL   = `SNOOP_REG_CTRL,
    REG_WMARK  = `SNOOP_REG_WMARK,
    REG_TRIG   = `SNOOP_REG_TRIG,
    REG_STATUS = `SNOOP_REG_STATUS,
    REG_SRC    = `SNOOP_REG_SRC,
    REG_DST    = `SNOOP_REG_DST,
    REG_INFO   = `SNOOP_REG_INFO
  } reg_e;

  reg_e                      reg_sel;
  logic                      access;
  logic                      wr_access;
  logic [31:0]               rdata;
  logic                      ack_q;
  logic [31:0]               rdata_q;
  logic                      enable_q;
  logic                      core_sel_q;
  logic                      trig_en_q;
  logic [4:0]                kind_mask_q;
  logic [`SNOOP_LEVEL_W-1:0] wmark_q;
  logic [`SNOOP_PC_W-1:0]    trig_addr_q;

  assign reg_sel   = reg_e'(wb_adr_i);
  // First cycle of a request, ack follows on the next one
  assign access    = wb_cyc_i && wb_stb_i && !ack_q;
  assign wr_access = access && wb_we_i;

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    rdata = '0;
    case (reg_sel)
      REG_CTRL:   rdata = {23'b0, kind_mask_q, 1'b0, trig_en_q, core_sel_q, enable_q};
      REG_WMARK:  rdata = {{(32 - `SNOOP_LEVEL_W){1'b0}}, wmark_q};
      REG_TRIG:   rdata = trig_addr_q;
      REG_STATUS: rdata = {22'b0, overflow_i, hit_i, 3'b0, level_i};
      REG_SRC:    rdata = empty_i ? '0 : head_i.src_pc;
      REG_DST:    rdata = empty_i ? '0 : head_i.dst_pc;
      REG_INFO:   rdata = empty_i ? '0 : {1'b1, 25'b0, head_i.priv, 1'b0, head_i.kind};
      default:    rdata = '0;
    endcase
  end

  // Bus handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata;
    end
  end

  // ------------------------------
  // Configuration registers
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q    <= 1'b0;
      core_sel_q  <= 1'b0;
      trig_en_q   <= 1'b0;
      kind_mask_q <= '0;
      wmark_q     <= '0;
      trig_addr_q <= '0;
    end else if (wr_access) begin
      case (reg_sel)
        REG_CTRL: begin
          enable_q    <= wb_dat_i[0];
          core_sel_q  <= wb_dat_i[1];
          trig_en_q   <= wb_dat_i[2];
          kind_mask_q <= wb_dat_i[8:4];
        end
        REG_WMARK: wmark_q     <= wb_dat_i[`SNOOP_LEVEL_W-1:0];
        REG_TRIG:  trig_addr_q <= wb_dat_i[`SNOOP_PC_W-1:0];
        default: ;
      endcase
    end
  end

  // Side effects land on the same edge as the register update
  assign pop_o     = access && !wb_we_i && (reg_sel == REG_INFO) && !empty_i;
  assign hit_clr_o = wr_access && (reg_sel == REG_STATUS) && wb_dat_i[8];
  assign ovf_clr_o = wr_access && (reg_sel == REG_STATUS) && wb_dat_i[9];

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rdata_q;

  assign cfg_enable_o    = enable_q;
  assign cfg_core_sel_o  = core_sel_q;
  assign cfg_kind_mask_o = kind_mask_q;
  assign cfg_trig_en_o   = trig_en_q;
  assign cfg_trig_addr_o = trig_addr_q;

  // Watermark of zero disables the interrupt
  assign watermark_irq_o = (wmark_q != '0) && (level_i >= wmark_q);
  assign trigger_irq_o   = hit_i;

endmodule

// ==== source/cfi_snoop_top.sv ====
/*
 * Top level of the control-flow trace snooper. Connects hart
 * selection, trace buffer, trigger unit and the Wishbone register
 * block. All logic runs on one clock.
 */

`timescale 1ns/1ns
`include "snoop_cfg.svh"

module cfi_snoop_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   hart0_valid_i,
  input  logic [`SNOOP_PC_W-1:0] hart0_src_pc_i,
  input  logic [`SNOOP_PC_W-1:0] hart0_dst_pc_i,
  input  snoop_pkg::br_kind_e    hart0_kind_i,
  input  snoop_pkg::priv_e       hart0_priv_i,
  input  logic                   hart1_valid_i,
  input  logic [`SNOOP_PC_W-1:0] hart1_src_pc_i,
  input  logic [`SNOOP_PC_W-1:0] hart1_dst_pc_i,
  input  snoop_pkg::br_kind_e    hart1_kind_i,
  input  snoop_pkg::priv_e       hart1_priv_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`SNOOP_WB_AW-1:0] wb_adr_i,
  input  logic [31:0]            wb_dat_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   watermark_irq_o,
  output logic                   trigger_irq_o
);
  import snoop_pkg::*;

  logic                      cfg_enable;
  logic                      cfg_core_sel;
  logic [4:0]                cfg_kind_mask;
  logic                      cfg_trig_en;
  logic [`SNOOP_PC_W-1:0]    cfg_trig_addr;
  trace_rec_t                rec;
  logic                      rec_valid;
  logic                      hit;
  logic                      hit_clr;
  logic                      pop;
  logic                      ovf_clr;
  trace_rec_t                head;
  logic                      empty;
  logic [`SNOOP_LEVEL_W-1:0] level;
  logic                      overflow;

  // ------------------------------
  // Selection front end
  // ------------------------------
  trace_select trace_select_inst (
    .clk_i           ( clk_i          ),
    .rst_i           ( rst_i          ),
    .hart0_valid_i   ( hart0_valid_i  ),
    .hart0_src_pc_i  ( hart0_src_pc_i ),
    .hart0_dst_pc_i  ( hart0_dst_pc_i ),
    .hart0_kind_i    ( hart0_kind_i   ),
    .hart0_priv_i    ( hart0_priv_i   ),
    .hart1_valid_i   ( hart1_valid_i  ),
    .hart1_src_pc_i  ( hart1_src_pc_i ),
    .hart1_dst_pc_i  ( hart1_dst_pc_i ),
    .hart1_kind_i    ( hart1_kind_i   ),
    .hart1_priv_i    ( hart1_priv_i   ),
    .cfg_enable_i    ( cfg_enable     ),
    .cfg_core_sel_i  ( cfg_core_sel   ),
    .cfg_kind_mask_i ( cfg_kind_mask  ),
    .rec_o           ( rec            ),
    .rec_valid_o     ( rec_valid      )
  );

  // Buffer and trigger see the same record
  trace_buffer #(
    .DEPTH ( `SNOOP_BUF_DEPTH )
  ) trace_buffer_inst (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .rec_i       ( rec       ),
    .rec_valid_i ( rec_valid ),
    .pop_i       ( pop       ),
    .ovf_clr_i   ( ovf_clr   ),
    .head_o      ( head      ),
    .empty_o     ( empty     ),
    .level_o     ( level     ),
    .overflow_o  ( overflow  )
  );

  trigger_unit trigger_unit_inst (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .rec_i           ( rec           ),
    .rec_valid_i     ( rec_valid     ),
    .cfg_trig_en_i   ( cfg_trig_en   ),
    .cfg_trig_addr_i ( cfg_trig_addr ),
    .hit_clr_i       ( hit_clr       ),
    .hit_o           ( hit           )
  );

  // ------------------------------
  // Register port
  // ------------------------------
  snoop_regs snoop_regs_inst (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .wb_cyc_i        ( wb_cyc_i        ),
    .wb_stb_i        ( wb_stb_i        ),
    .wb_we_i         ( wb_we_i         ),
    .wb_adr_i        ( wb_adr_i        ),
    .wb_dat_i        ( wb_dat_i        ),
    .head_i          ( head            ),
    .empty_i         ( empty           ),
    .level_i         ( level           ),
    .overflow_i      ( overflow        ),
    .hit_i           ( hit             ),
    .wb_dat_o        ( wb_dat_o        ),
    .wb_ack_o        ( wb_ack_o        ),
    .cfg_enable_o    ( cfg_enable      ),
    .cfg_core_sel_o  ( cfg_core_sel    ),
    .cfg_kind_mask_o ( cfg_kind_mask   ),
    .cfg_trig_en_o   ( cfg_trig_en     ),
    .cfg_trig_addr_o ( cfg_trig_addr   ),
    .pop_o           ( pop             ),
    .ovf_clr_o       ( ovf_clr         ),
    .hit_clr_o       ( hit_clr         ),
    .watermark_irq_o ( watermark_irq_o ),
    .trigger_irq_o   ( trigger_irq_o   )
  );

endmodule

// ==== bench/cfi_snoop_tb.sv ====
/*
 * Directed testbench of the trace snooper. Drives both hart event
 * streams and the Wishbone port, keeps a reference queue of the
 * records the filter should accept, and checks readout, fill level,
 * overflow and both interrupts against it.
 */

`timescale 1ns/1ns
`include "snoop_cfg.svh"

module cfi_snoop_tb;
  import snoop_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int ACK_LIMIT  = 16;
  // Reset plus 3 cycles per bus access, 2 per event and 3 per settle wait
  localparam int WORST_CYCLES = 8 + 200 * 3 + 60 * 2 + 20 * 3;
  localparam int WATCHDOG_NS  = 20 * WORST_CYCLES * CLK_PERIOD;

  logic                    clk;
  logic                    rst;
  logic                    hart_valid [2];
  logic [`SNOOP_PC_W-1:0]  hart_src [2];
  logic [`SNOOP_PC_W-1:0]  hart_dst [2];
  br_kind_e                hart_kind [2];
  priv_e                   hart_priv [2];
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [`SNOOP_WB_AW-1:0] wb_adr;
  logic [31:0]             wb_dat_w;
  logic [31:0]             wb_dat_r;
  logic                    wb_ack;
  logic                    wmark_irq;
  logic                    trig_irq;

  // Reference model
  trace_rec_t  exp_q [$];
  priv_e       privs [3] = '{PRIV_U, PRIV_S, PRIV_M};
  logic        m_enable;
  logic        m_sel;
  logic        m_trig_en;
  logic [4:0]  m_mask;
  logic [31:0] m_trig;
  logic        m_hit;
  logic        m_ovf;
  int          error_count;
  int          check_count;
  int          test_count;

  cfi_snoop_top cfi_snoop_top_inst (
    .clk_i           ( clk           ),
    .rst_i           ( rst           ),
    .hart0_valid_i   ( hart_valid[0] ),
    .hart0_src_pc_i  ( hart_src[0]   ),
    .hart0_dst_pc_i  ( hart_dst[0]   ),
    .hart0_kind_i    ( hart_kind[0]  ),
    .hart0_priv_i    ( hart_priv[0]  ),
    .hart1_valid_i   ( hart_valid[1] ),
    .hart1_src_pc_i  ( hart_src[1]   ),
    .hart1_dst_pc_i  ( hart_dst[1]   ),
    .hart1_kind_i    ( hart_kind[1]  ),
    .hart1_priv_i    ( hart_priv[1]  ),
    .wb_cyc_i        ( wb_cyc        ),
    .wb_stb_i        ( wb_stb        ),
    .wb_we_i         ( wb_we         ),
    .wb_adr_i        ( wb_adr        ),
    .wb_dat_i        ( wb_dat_w      ),
    .wb_dat_o        ( wb_dat_r      ),
    .wb_ack_o        ( wb_ack        ),
    .watermark_irq_o ( wmark_irq     ),
    .trigger_irq_o   ( trig_irq      )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      $display("[ERROR] %s: got %08h, expected %08h", name, got, expected);
      error_count++;
    end
  endtask

  // One classic cycle held until ack
  task automatic bus_transfer(input logic we, input logic [`SNOOP_WB_AW-1:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (!wb_ack) begin
      $display("Wishbone access to offset %02h got no ack within %0d cycles", adr, ACK_LIMIT);
      error_count++;
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [`SNOOP_WB_AW-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_transfer(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [`SNOOP_WB_AW-1:0] adr, output logic [31:0] data);
    bus_transfer(1'b0, adr, 32'h0, data);
  endtask

  task automatic write_ctrl(input logic en, input logic sel, input logic trig_en,
                            input logic [4:0] mask);
    wb_write(`SNOOP_REG_CTRL, {23'b0, mask, 1'b0, trig_en, sel, en});
    m_enable  = en;
    m_sel     = sel;
    m_trig_en = trig_en;
    m_mask    = mask;
  endtask

  // One-cycle event after which the model decides what the DUT keeps
  task automatic send_event(input int h, input logic [31:0] src, input logic [31:0] dst,
                            input br_kind_e kind, input priv_e priv);
    logic accept;
    @(posedge clk);
    #1;
    hart_valid[h] = 1'b1;
    hart_src[h]   = src;
    hart_dst[h]   = dst;
    hart_kind[h]  = kind;
    hart_priv[h]  = priv;
    @(posedge clk);
    #1;
    hart_valid[h] = 1'b0;
    accept = m_enable && (h == int'(m_sel)) && m_mask[kind];
    if (accept) begin
      if (exp_q.size() < `SNOOP_BUF_DEPTH) begin
        exp_q.push_back('{src_pc: src, dst_pc: dst, kind: kind, priv: priv});
      end else begin
        m_ovf = 1'b1;
      end
      if (m_trig_en && dst == m_trig) begin
        m_hit = 1'b1;
      end
    end
  endtask

  // Event to STATUS visibility is three cycles
  task automatic settle();
    repeat (3) @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] status_word();
    return {22'b0, m_ovf, m_hit, 3'b0, 5'(exp_q.size())};
  endfunction

  task automatic check_status();
    logic [31:0] data;
    wb_read(`SNOOP_REG_STATUS, data);
    check_value("STATUS", data, status_word());
  endtask

  task automatic drain_expected(input int count);
    trace_rec_t  exp_rec;
    logic [31:0] data;
    for (int i = 0; i < count; i++) begin
      exp_rec = exp_q.pop_front();
      wb_read(`SNOOP_REG_SRC, data);
      check_value("SRC", data, exp_rec.src_pc);
      wb_read(`SNOOP_REG_DST, data);
      check_value("DST", data, exp_rec.dst_pc);
      wb_read(`SNOOP_REG_INFO, data);
      check_value("INFO", data, {1'b1, 25'b0, exp_rec.priv, 1'b0, exp_rec.kind});
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_count++;
    if (error_count == err_start) begin
      $display("%-18s done, no errors", name);
    end else begin
      $display("%-18s done, %0d errors", name, error_count - err_start);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset_regs();
    int          err_start;
    logic [31:0] data;
    logic [31:0] addr;
    err_start = error_count;
    addr = $urandom();
    check_status();
    check_value("watermark_irq_o", {31'b0, wmark_irq}, 32'h0);
    check_value("trigger_irq_o", {31'b0, trig_irq}, 32'h0);
    wb_read(`SNOOP_REG_CTRL, data);
    check_value("CTRL", data, 32'h0);
    wb_read(`SNOOP_REG_WMARK, data);
    check_value("WMARK", data, 32'h0);
    wb_read(`SNOOP_REG_TRIG, data);
    check_value("TRIG", data, 32'h0);
    wb_write(`SNOOP_REG_CTRL, 32'hFFFF_FFFF);
    wb_read(`SNOOP_REG_CTRL, data);
    check_value("CTRL", data, 32'h0000_01F7);
    write_ctrl(1'b0, 1'b0, 1'b0, 5'h00);
    wb_write(`SNOOP_REG_WMARK, 32'h15);
    wb_read(`SNOOP_REG_WMARK, data);
    check_value("WMARK", data, 32'h15);
    wb_write(`SNOOP_REG_TRIG, addr);
    wb_read(`SNOOP_REG_TRIG, data);
    check_value("TRIG", data, addr);
    wb_read(5'h1C, data);
    check_value("unmapped", data, 32'h0);
    wb_write(`SNOOP_REG_WMARK, 32'h0);
    wb_write(`SNOOP_REG_TRIG, 32'h0);
    finish_test("reset_regs", err_start);
  endtask

  task automatic test_capture();
    int          err_start;
    logic [31:0] data;
    err_start = error_count;
    write_ctrl(1'b1, 1'b0, 1'b0, 5'h1F);
    for (int i = 0; i < 5; i++) begin
      send_event(0, $urandom(), $urandom(), br_kind_e'(3'(i)), privs[i % 3]);
    end
    settle();
    check_status();
    drain_expected(exp_q.size());
    wb_read(`SNOOP_REG_INFO, data);
    check_value("INFO", data, 32'h0);
    // Empty buffer shows zero PCs
    wb_read(`SNOOP_REG_SRC, data);
    check_value("SRC", data, 32'h0);
    wb_read(`SNOOP_REG_DST, data);
    check_value("DST", data, 32'h0);
    finish_test("capture_readout", err_start);
  endtask

  task automatic test_select_mask();
    int err_start;
    err_start = error_count;
    // Hart 1 with jumps and returns only
    write_ctrl(1'b1, 1'b1, 1'b0, 5'b01010);
    for (int i = 0; i < 12; i++) begin
      send_event(i % 2, $urandom(), $urandom(), br_kind_e'(3'(i % 5)), PRIV_S);
    end
    write_ctrl(1'b0, 1'b1, 1'b0, 5'h1F);
    send_event(1, $urandom(), $urandom(), BR_CALL, PRIV_U);
    settle();
    check_status();
    drain_expected(exp_q.size());
    finish_test("select_mask", err_start);
  endtask

  task automatic test_watermark();
    int err_start;
    err_start = error_count;
    write_ctrl(1'b1, 1'b0, 1'b0, 5'h1F);
    wb_write(`SNOOP_REG_WMARK, 32'd4);
    for (int i = 0; i < 3; i++) begin
      send_event(0, $urandom(), $urandom(), BR_CALL, PRIV_M);
    end
    settle();
    check_value("watermark_irq_o", {31'b0, wmark_irq}, 32'h0);
    send_event(0, $urandom(), $urandom(), BR_RET, PRIV_M);
    settle();
    check_value("watermark_irq_o", {31'b0, wmark_irq}, 32'h1);
    drain_expected(1);
    check_value("watermark_irq_o", {31'b0, wmark_irq}, 32'h0);
    drain_expected(exp_q.size());
    wb_write(`SNOOP_REG_WMARK, 32'h0);
    finish_test("watermark", err_start);
  endtask

  task automatic test_overflow();
    int err_start;
    err_start = error_count;
    write_ctrl(1'b1, 1'b0, 1'b0, 5'h1F);
    for (int i = 0; i < 20; i++) begin
      send_event(0, $urandom(), $urandom(), br_kind_e'(3'(i % 5)), privs[i % 3]);
    end
    settle();
    check_status();
    wb_write(`SNOOP_REG_STATUS, 32'h200);
    m_ovf = 1'b0;
    check_status();
    drain_expected(exp_q.size());
    check_status();
    finish_test("overflow", err_start);
  endtask

  task automatic test_trigger();
    int          err_start;
    logic [31:0] target;
    err_start = error_count;
    target = $urandom();
    m_trig = target;
    wb_write(`SNOOP_REG_TRIG, target);
    write_ctrl(1'b1, 1'b0, 1'b1, 5'h1F);
    send_event(0, $urandom(), target ^ 32'h4, BR_JUMP, PRIV_S);
    settle();
    check_value("trigger_irq_o", {31'b0, trig_irq}, 32'h0);
    send_event(0, $urandom(), target, BR_JUMP, PRIV_S);
    settle();
    check_value("trigger_irq_o", {31'b0, trig_irq}, 32'h1);
    check_status();
    wb_write(`SNOOP_REG_STATUS, 32'h100);
    m_hit = 1'b0;
    check_value("trigger_irq_o", {31'b0, trig_irq}, 32'h0);
    write_ctrl(1'b1, 1'b0, 1'b0, 5'h1F);
    send_event(0, $urandom(), target, BR_CALL, PRIV_U);
    settle();
    check_value("trigger_irq_o", {31'b0, trig_irq}, 32'h0);
    drain_expected(exp_q.size());
    finish_test("trigger", err_start);
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    for (int h = 0; h < 2; h++) begin
      hart_valid[h] = 1'b0;
      hart_src[h]   = '0;
      hart_dst[h]   = '0;
      hart_kind[h]  = BR_COND;
      hart_priv[h]  = PRIV_U;
    end
    m_enable    = 1'b0;
    m_sel       = 1'b0;
    m_trig_en   = 1'b0;
    m_mask      = '0;
    m_trig      = '0;
    m_hit       = 1'b0;
    m_ovf       = 1'b0;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    void'($urandom(32'h5068_5395));
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_regs();
    test_capture();
    test_select_mask();
    test_watermark();
    test_overflow();
    test_trigger();

    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
source/snoop_pkg.sv
source/trace_select.sv
source/trace_buffer.sv
source/trigger_unit.sv
source/snoop_regs.sv
source/cfi_snoop_top.sv
bench/cfi_snoop_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the trace snooper testbench with Verilator, runs it and
# decides the result from the simulation log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module cfi_snoop_tb \
  -Mdir "$BUILD_DIR" -o cfi_snoop_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/cfi_snoop_sim" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** FAILED ***" "$LOG_FILE"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
